//--- hdl/clockCtrlPkg.sv
// clock control package: shared types, register map and sequencer states
package clockCtrlPkg;

  // register bus word and word address
  typedef logic [31:0] csrWordT;
  typedef logic [3:0]  csrAddrT;

  // bit i of the map enables the cycle at map position i
  typedef logic [7:0]  throttleMapT;

  typedef logic [15:0] countT;

  // domain reset sequencer
  typedef enum logic [1:0] {
    seqHold,
    seqCount,
    seqRun
  } seqStateT;

  // word addresses, channel c sits at AddrChannelBase + c
  localparam csrAddrT AddrId          = 4'd0;
  localparam csrAddrT AddrControl     = 4'd1;
  localparam csrAddrT AddrChannelBase = 4'd2;

  // control word
  localparam int CtlSoftResetBit      = 0;
  localparam int CtlThermalWarningBit = 20;
  localparam int CtlResetBusyBit      = 31;

  // channel word
  localparam int ChForcedBit        = 0;
  localparam int ChEnableWarningBit = 1;
  localparam int ChMapLsb           = 8;
  localparam int ChCountLsb         = 16;

  // upper 24 bits of the ID word
  localparam logic [23:0] CsrIdBase = 24'hC1C0A5;

endpackage

//--- hdl/chanCtrlIf.sv
// channel control interface: control fields from the register bank, activity count back
`timescale 1ns/1ps

interface chanCtrlIf;

  logic                      forced;
  logic                      enableWarning;
  clockCtrlPkg::throttleMapT throttleMap;
  clockCtrlPkg::countT       count;

  // register bank side
  modport bank (
    output forced,
    output enableWarning,
    output throttleMap,
    input  count
  );

  // throttle and meter side
  modport channel (
    input  forced,
    input  enableWarning,
    input  throttleMap,
    output count
  );

endinterface

//--- hdl/csrBank.sv
// register bank: decodes the strobed register bus, holds control fields, returns read data
`timescale 1ns/1ps

module csrBank #(
  parameter int ChannelCount = 2
) (
  input  logic                  clockOut,
  input  logic                  arstN,
  input  logic                  csrWrite,
  input  logic                  csrRead,
  input  clockCtrlPkg::csrAddrT csrAddr,
  input  clockCtrlPkg::csrWordT csrWdata,
  input  logic                  thermalWarning,
  input  logic                  resetOut,
  output clockCtrlPkg::csrWordT csrRdata,
  output logic                  csrReadValid,
  output logic                  softReset,
  chanCtrlIf.bank               chan [ChannelCount-1:0]
);

  localparam clockCtrlPkg::csrWordT IdWord = {clockCtrlPkg::CsrIdBase, 8'(ChannelCount)};

  logic                      forcedReg        [ChannelCount-1:0];
  logic                      enableWarningReg [ChannelCount-1:0];
  clockCtrlPkg::throttleMapT mapReg           [ChannelCount-1:0];
  clockCtrlPkg::countT       chanCount        [ChannelCount-1:0];
  clockCtrlPkg::csrWordT     chanWord         [ChannelCount-1:0];
  clockCtrlPkg::csrWordT     controlWord;
  clockCtrlPkg::csrWordT     readWord;

  for (genvar c = 0; c < ChannelCount; c++) begin : chanWire
    assign chan[c].forced        = forcedReg[c];
    assign chan[c].enableWarning = enableWarningReg[c];
    assign chan[c].throttleMap   = mapReg[c];
    assign chanCount[c]          = chan[c].count;
  end

  // writable fields, read-only bits are simply not stored
  always_ff @(posedge clockOut or negedge arstN) begin
    if (!arstN) begin
      softReset <= 1'b0;
      for (int c = 0; c < ChannelCount; c++) begin
        forcedReg[c]        <= 1'b0;
        enableWarningReg[c] <= 1'b0;
        mapReg[c]           <= '0;
      end
    end else if (csrWrite) begin
      if (csrAddr == clockCtrlPkg::AddrControl) begin
        softReset <= csrWdata[clockCtrlPkg::CtlSoftResetBit];
      end
      for (int c = 0; c < ChannelCount; c++) begin
        if (csrAddr == clockCtrlPkg::csrAddrT'(clockCtrlPkg::AddrChannelBase + c)) begin
          forcedReg[c]        <= csrWdata[clockCtrlPkg::ChForcedBit];
          enableWarningReg[c] <= csrWdata[clockCtrlPkg::ChEnableWarningBit];
          mapReg[c]           <= csrWdata[clockCtrlPkg::ChMapLsb +: 8];
        end
      end
    end
  end

  // assemble status and channel words
  always_comb begin
    controlWord = '0;
    controlWord[clockCtrlPkg::CtlSoftResetBit]      = softReset;
    controlWord[clockCtrlPkg::CtlThermalWarningBit] = thermalWarning;
    controlWord[clockCtrlPkg::CtlResetBusyBit]      = resetOut;
    for (int c = 0; c < ChannelCount; c++) begin
      chanWord[c] = '0;
      chanWord[c][clockCtrlPkg::ChForcedBit]        = forcedReg[c];
      chanWord[c][clockCtrlPkg::ChEnableWarningBit] = enableWarningReg[c];
      chanWord[c][clockCtrlPkg::ChMapLsb +: 8]      = mapReg[c];
      chanWord[c][clockCtrlPkg::ChCountLsb +: 16]   = chanCount[c];
    end
  end

  // read mux, unmapped addresses give zero
  always_comb begin
    readWord = '0;
    if (csrAddr == clockCtrlPkg::AddrId) begin
      readWord = IdWord;
    end else if (csrAddr == clockCtrlPkg::AddrControl) begin
      readWord = controlWord;
    end
    for (int c = 0; c < ChannelCount; c++) begin
      if (csrAddr == clockCtrlPkg::csrAddrT'(clockCtrlPkg::AddrChannelBase + c)) begin
        readWord = chanWord[c];
      end
    end
  end

  // one-cycle read response, data is zero outside it
  always_ff @(posedge clockOut or negedge arstN) begin
    if (!arstN) begin
      csrRdata     <= '0;
      csrReadValid <= 1'b0;
    end else begin
      csrRdata     <= csrRead ? readWord : '0;
      csrReadValid <= csrRead;
    end
  end

endmodule

//--- hdl/clockThrottle.sv
// clock throttle: per-channel clock enable that walks the throttle map when throttling
`timescale 1ns/1ps

module clockThrottle (
  input  logic       clockOut,
  input  logic       arstN,
  input  logic       resetOut,
  input  logic       thermalWarning,
  chanCtrlIf.channel chan,
  output logic       clockEnable
);

  logic [2:0] mapPtr;
  logic       throttling;

  // pointer restarts at position 0 on the first cycle out of reset
  always_ff @(posedge clockOut or negedge arstN) begin
    if (!arstN) begin
      mapPtr <= '0;
    end else if (resetOut) begin
      mapPtr <= '0;
    end else begin
      mapPtr <= mapPtr + 3'd1;
    end
  end

  assign throttling = chan.forced || (thermalWarning && chan.enableWarning);

  // same-cycle response to control changes
  always_comb begin
    if (resetOut) begin
      clockEnable = 1'b0;
    end else if (throttling) begin
      clockEnable = chan.throttleMap[mapPtr];
    end else begin
      clockEnable = 1'b1;
    end
  end

endmodule

//--- hdl/activityMeter.sv
// activity meter: prescaled count of enabled cycles for one channel
`timescale 1ns/1ps

module activityMeter #(
  parameter int PrescaleW = 3
) (
  input  logic       clockOut,
  input  logic       arstN,
  input  logic       resetOut,
  input  logic       clockEnable,
  chanCtrlIf.channel chan
);

  logic [PrescaleW-1:0] prescale;
  clockCtrlPkg::countT  count;

  always_ff @(posedge clockOut or negedge arstN) begin
    if (!arstN) begin
      prescale <= '0;
      count    <= '0;
    end else if (resetOut) begin
      prescale <= '0;
      count    <= '0;
    end else if (clockEnable) begin
      prescale <= prescale + 1'b1;
      // one count per full prescaler turn, wraps at 16 bits
      if (&prescale) begin
        count <= count + 16'd1;
      end
    end
  end

  assign chan.count = count;

endmodule

//--- hdl/resetSequencer.sv
// reset sequencer: holds the domain reset for a fixed number of cycles after release
`timescale 1ns/1ps

module resetSequencer #(
  parameter int ResetCycles = 16
) (
  input  logic clockOut,
  input  logic arstN,
  input  logic softReset,
  output logic resetOut
);

  localparam int CountW = $clog2(ResetCycles + 1);

  clockCtrlPkg::seqStateT state;
  logic [CountW-1:0]      holdCount;

  always_ff @(posedge clockOut or negedge arstN) begin
    if (!arstN) begin
      state     <= clockCtrlPkg::seqHold;
      holdCount <= '0;
    end else begin
      case (state)
        clockCtrlPkg::seqHold: begin
          // first edge after release counts as edge one
          if (!softReset) begin
            state     <= clockCtrlPkg::seqCount;
            holdCount <= CountW'(1);
          end
        end
        clockCtrlPkg::seqCount: begin
          if (softReset) begin
            state <= clockCtrlPkg::seqHold;
          end else if (holdCount == CountW'(ResetCycles - 1)) begin
            state <= clockCtrlPkg::seqRun;
          end else begin
            holdCount <= holdCount + 1'b1;
          end
        end
        clockCtrlPkg::seqRun: begin
          if (softReset) begin
            state <= clockCtrlPkg::seqHold;
          end
        end
        default: state <= clockCtrlPkg::seqHold;
      endcase
    end
  end

  // busy in hold and count
  assign resetOut = (state != clockCtrlPkg::seqRun);

endmodule

//--- hdl/clockCtrlTop.sv
// clock control top: register bank, domain reset and per-channel throttled clock enables
`timescale 1ns/1ps

module clockCtrlTop #(
  parameter int ChannelCount = 2,
  parameter int PrescaleW    = 3,
  parameter int ResetCycles  = 16
) (
  input  logic                    clockOut,
  input  logic                    arstN,
  input  logic                    thermalWarning,
  input  logic                    csrWrite,
  input  logic                    csrRead,
  input  clockCtrlPkg::csrAddrT   csrAddr,
  input  clockCtrlPkg::csrWordT   csrWdata,
  output clockCtrlPkg::csrWordT   csrRdata,
  output logic                    csrReadValid,
  output logic                    resetOut,
  output logic [ChannelCount-1:0] clockEnable
);

  logic softReset;

  chanCtrlIf chanIf [ChannelCount-1:0] ();

  csrBank #(
    .ChannelCount(ChannelCount)
  ) bank0 (
    .clockOut       (clockOut),
    .arstN          (arstN),
    .csrWrite       (csrWrite),
    .csrRead        (csrRead),
    .csrAddr        (csrAddr),
    .csrWdata       (csrWdata),
    .thermalWarning (thermalWarning),
    .resetOut       (resetOut),
    .csrRdata       (csrRdata),
    .csrReadValid   (csrReadValid),
    .softReset      (softReset),
    .chan           (chanIf)
  );

  resetSequencer #(
    .ResetCycles(ResetCycles)
  ) seq0 (
    .clockOut  (clockOut),
    .arstN     (arstN),
    .softReset (softReset),
    .resetOut  (resetOut)
  );

  // one throttle and one meter per channel
  for (genvar c = 0; c < ChannelCount; c++) begin : chanGen
    clockThrottle throttle0 (
      .clockOut       (clockOut),
      .arstN          (arstN),
      .resetOut       (resetOut),
      .thermalWarning (thermalWarning),
      .chan           (chanIf[c]),
      .clockEnable    (clockEnable[c])
    );

    activityMeter #(
      .PrescaleW(PrescaleW)
    ) meter0 (
      .clockOut    (clockOut),
      .arstN       (arstN),
      .resetOut    (resetOut),
      .clockEnable (clockEnable[c]),
      .chan        (chanIf[c])
    );
  end

endmodule

//--- verification/clockCtrlTb.sv
// clock control testbench with table-driven register, throttle, meter and reset checks
`timescale 1ns/1ps

module clockCtrlTb;

  localparam int ChannelCount = 2;
  localparam int PrescaleW    = 3;
  localparam int ResetCycles  = 16;

  typedef enum {opWrite, opRead, opWait, opSetWarning, opCheckEnable, opCheckRelease} opT;

  // opRead data picks the compare (0 word, 1 count baseline, 2 count delta, 3 low half)
  typedef struct {
    opT                    op;
    clockCtrlPkg::csrAddrT addr;
    clockCtrlPkg::csrWordT data;
    clockCtrlPkg::csrWordT expected;
  } stepT;

  logic                    clockOut;
  logic                    arstN;
  logic                    thermalWarning;
  logic                    csrWrite;
  logic                    csrRead;
  clockCtrlPkg::csrAddrT   csrAddr;
  clockCtrlPkg::csrWordT   csrWdata;
  clockCtrlPkg::csrWordT   csrRdata;
  logic                    csrReadValid;
  logic                    resetOut;
  logic [ChannelCount-1:0] clockEnable;

  stepT                  steps[$];
  bit                    tableBuilt;
  int                    seed;
  clockCtrlPkg::countT   lastCount;

  clockCtrlTop #(
    .ChannelCount(ChannelCount),
    .PrescaleW(PrescaleW),
    .ResetCycles(ResetCycles)
  ) dut0 (
    .clockOut       (clockOut),
    .arstN          (arstN),
    .thermalWarning (thermalWarning),
    .csrWrite       (csrWrite),
    .csrRead        (csrRead),
    .csrAddr        (csrAddr),
    .csrWdata       (csrWdata),
    .csrRdata       (csrRdata),
    .csrReadValid   (csrReadValid),
    .resetOut       (resetOut),
    .clockEnable    (clockEnable)
  );

  always #50 clockOut = ~clockOut;

  task automatic stopOnError();
    $display("TEST FAILED");
    $fatal(1, "first error reached");
  endtask

  task automatic checkWord(string name, clockCtrlPkg::csrWordT exp, clockCtrlPkg::csrWordT act);
    if (exp !== act) begin
      $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
      stopOnError();
    end
  endtask

  task automatic checkCount(string name, clockCtrlPkg::countT exp, clockCtrlPkg::countT act);
    if (exp !== act) begin
      $display("mismatch at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
      stopOnError();
    end
  endtask

  task automatic checkBit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("mismatch at %0t ns: %s expected %b got %b", $time, name, exp, act);
      stopOnError();
    end
  endtask

  // outside a read response the bus shows no valid pulse and zero data
  task automatic checkBusIdle();
    checkBit("csrReadValid", 1'b0, csrReadValid);
    checkWord("csrRdata", 32'h0, csrRdata);
  endtask

  function automatic int countOnes(clockCtrlPkg::throttleMapT m);
    int n;
    n = 0;
    for (int i = 0; i < 8; i++) begin
      n += int'(m[i]);
    end
    return n;
  endfunction

  task automatic addStep(opT op, clockCtrlPkg::csrAddrT addr, clockCtrlPkg::csrWordT data,
                         clockCtrlPkg::csrWordT expected);
    stepT s;
    s.op       = op;
    s.addr     = addr;
    s.data     = data;
    s.expected = expected;
    steps.push_back(s);
  endtask

  // call right after the edge on which the reset source was released
  task automatic watchRelease();
    clockCtrlPkg::csrWordT busyWord;
    busyWord = '0;
    busyWord[clockCtrlPkg::CtlResetBusyBit] = 1'b1;
    for (int i = 1; i <= ResetCycles; i++) begin
      @(posedge clockOut);
      csrAddr <= clockCtrlPkg::AddrControl;
      csrRead <= (i == 4);
      @(negedge clockOut);
      checkBit("resetOut", (i < ResetCycles), resetOut);
      if (i < ResetCycles) begin
        checkBit("clockEnable[0]", 1'b0, clockEnable[0]);
        checkBit("clockEnable[1]", 1'b0, clockEnable[1]);
      end
      if (i == 5) begin
        checkBit("csrReadValid", 1'b1, csrReadValid);
        checkWord("csrRdata", busyWord, csrRdata);
      end else begin
        checkBusIdle();
      end
    end
  endtask

  task automatic applyStep(stepT s);
    int enabled;
    case (s.op)
      opWrite: begin
        @(posedge clockOut);
        csrWrite <= 1'b1;
        csrAddr  <= s.addr;
        csrWdata <= s.data;
        @(posedge clockOut);
        csrWrite <= 1'b0;
      end
      opRead: begin
        @(posedge clockOut);
        csrRead <= 1'b1;
        csrAddr <= s.addr;
        @(posedge clockOut);
        csrRead <= 1'b0;
        @(negedge clockOut);
        checkBit("csrReadValid", 1'b1, csrReadValid);
        if (s.data == 0) begin
          checkWord("csrRdata", s.expected, csrRdata);
        end else if (s.data == 3) begin
          checkWord("csrRdata low half", s.expected, csrRdata & 32'h0000_FFFF);
        end else if (s.data == 2) begin
          checkCount("count delta", s.expected[15:0], csrRdata[31:16] - lastCount);
        end
        lastCount = csrRdata[31:16];
      end
      opWait: begin
        repeat (s.data) begin
          @(posedge clockOut);
          @(negedge clockOut);
          checkBusIdle();
        end
      end
      opSetWarning: begin
        @(posedge clockOut);
        thermalWarning <= s.data[0];
      end
      opCheckEnable: begin
        enabled = 0;
        repeat (s.data) begin
          @(posedge clockOut);
          @(negedge clockOut);
          enabled += int'(clockEnable[s.addr[0]]);
          checkBusIdle();
        end
        checkCount("clockEnable cycles", s.expected[15:0], clockCtrlPkg::countT'(enabled));
      end
      default: begin
        watchRelease();
      end
    endcase
  endtask

  // table length times one full meter window plus a margin
  initial begin
    wait (tableBuilt);
    #((steps.size() * 8 * (2 ** PrescaleW) + 200) * 100);
    $display("timeout: the test table did not finish in time");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clockCtrlPkg::throttleMapT map0;
    clockCtrlPkg::throttleMapT map1;
    seed = 21306;
    clockOut = 1'b0;
    arstN = 1'b0;
    thermalWarning = 1'b0;
    csrWrite = 1'b0;
    csrRead = 1'b0;
    csrAddr = '0;
    csrWdata = '0;
    lastCount = '0;
    map0 = clockCtrlPkg::throttleMapT'($random(seed));
    map1 = clockCtrlPkg::throttleMapT'($random(seed));

    // register map
    addStep(opRead, 4'd1, 0, 32'h0);
    addStep(opRead, 4'd0, 0, {clockCtrlPkg::CsrIdBase, 8'd2});
    addStep(opRead, 4'd15, 0, 32'h0);
    addStep(opWrite, 4'd2, 32'hFFFF_FFFF, 0);
    addStep(opRead, 4'd2, 3, 32'h0000_FF03);
    addStep(opWrite, 4'd0, 32'hFFFF_FFFF, 0);
    addStep(opRead, 4'd0, 0, {clockCtrlPkg::CsrIdBase, 8'd2});
    addStep(opCheckEnable, 4'd1, 16, 16);
    // forced throttling on channel 0
    addStep(opWrite, 4'd2, {16'h0, map0, 8'h01}, 0);
    addStep(opCheckEnable, 4'd0, 8, clockCtrlPkg::csrWordT'(countOnes(map0)));
    addStep(opCheckEnable, 4'd0, 16, clockCtrlPkg::csrWordT'(2 * countOnes(map0)));
    addStep(opWait, 0, 8, 0);
    addStep(opRead, 4'd2, 1, 0);
    addStep(opWait, 0, 62, 0);
    addStep(opRead, 4'd2, 2, clockCtrlPkg::csrWordT'(countOnes(map0)));
    // free running channel 1
    addStep(opRead, 4'd3, 1, 0);
    addStep(opWait, 0, 62, 0);
    addStep(opRead, 4'd3, 2, 8);
    // thermal throttling on channel 1
    addStep(opWrite, 4'd3, {16'h0, map1, 8'h02}, 0);
    addStep(opCheckEnable, 4'd1, 8, 8);
    addStep(opSetWarning, 0, 1, 0);
    addStep(opRead, 4'd1, 0, 32'h0010_0000);
    addStep(opCheckEnable, 4'd1, 8, clockCtrlPkg::csrWordT'(countOnes(map1)));
    addStep(opRead, 4'd3, 1, 0);
    addStep(opWait, 0, 62, 0);
    addStep(opRead, 4'd3, 2, clockCtrlPkg::csrWordT'(countOnes(map1)));
    addStep(opWrite, 4'd3, {16'h0, map1, 8'h00}, 0);
    addStep(opCheckEnable, 4'd1, 8, 8);
    addStep(opSetWarning, 0, 0, 0);
    // software reset
    addStep(opWrite, 4'd2, 32'h0, 0);
    addStep(opWrite, 4'd1, 32'h1, 0);
    addStep(opCheckEnable, 4'd0, 8, 0);
    addStep(opRead, 4'd1, 0, 32'h8000_0001);
    addStep(opRead, 4'd2, 0, 32'h0);
    addStep(opWrite, 4'd1, 32'h0, 0);
    addStep(opCheckRelease, 0, 0, 0);
    addStep(opWait, 0, 22, 0);
    addStep(opRead, 4'd2, 0, 32'h0002_0000);
    tableBuilt = 1'b1;

    repeat (3) @(posedge clockOut);
    arstN <= 1'b1;
    watchRelease();
    foreach (steps[i]) begin
      applyStep(steps[i]);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

//--- clockCtrl.f
hdl/clockCtrlPkg.sv
hdl/chanCtrlIf.sv
hdl/csrBank.sv
hdl/clockThrottle.sv
hdl/activityMeter.sv
hdl/resetSequencer.sv
hdl/clockCtrlTop.sv
verification/clockCtrlTb.sv

//--- run.sh
#!/bin/sh
# compile and run the clockCtrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module clockCtrlTb -f clockCtrl.f -o clockCtrlSim

./obj_dir/clockCtrlSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
